// File: logic/credit_bank.sv
`timescale 1ns/1ns
`default_nettype none

module credit_bank
	import wrr_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire req_vec_t req,
	input wire req_vec_t grant,
	input wire wrr_cfg_t cfg,
	output req_vec_t credit_empty_next
);

	// one counter per requester, index i belongs to requester i
	credit_t [NUM_REQ-1:0] credit_q;
	credit_t [NUM_REQ-1:0] credit_next;

	// every counter has run dry, so the whole bank refills from cfg
	logic reload;

	// requesters that hold the grant, still request and have credit left
	req_vec_t spend;

	// set where the current counter is zero
	req_vec_t credit_zero;

	// ************************************************************
	// reload and spend conditions
	// ************************************************************

	always_comb
	begin
		for (int i = 0; i < NUM_REQ; i++)
		begin
			credit_zero[i] = (credit_q[i] == '0);
		end
	end

	assign reload = &credit_zero;

	// a requester that drops its request while granted keeps its credit,
	// and an empty counter does not wrap around
	assign spend = grant & req & ~credit_zero;

	// ************************************************************
	// next credit per requester
	// ************************************************************

	always_comb
	begin
		for (int i = 0; i < NUM_REQ; i++)
		begin
			if (reload)
			begin
				credit_next[i] = cfg.weight[i];
			end
			else if (spend[i])
			begin
				credit_next[i] = credit_q[i] - 1'b1;
			end
			else
			begin
				credit_next[i] = credit_q[i];
			end
		end
	end

	// the pointer logic only needs to know which counters end up empty
	always_comb
	begin
		for (int i = 0; i < NUM_REQ; i++)
		begin
			credit_empty_next[i] = (credit_next[i] == '0);
		end
	end

	// ************************************************************
	// counter registers
	// ************************************************************

	// all counters start empty, so the first cycle out of reset reloads
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			credit_q <= '0;
		end
		else
		begin
			credit_q <= credit_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/grant_pointer_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module grant_pointer_ctrl
	import wrr_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire req_vec_t pick,
	input wire req_vec_t credit_empty_next,
	output req_vec_t grant,
	output ptr_t ptr
);

	req_vec_t grant_next;
	ptr_t ptr_next;

	// ************************************************************
	// grant
	// ************************************************************

	// the requester holding the grant now cannot win the next cycle,
	// which leaves a zero grant when it is the only candidate
	assign grant_next = pick & ~grant;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			grant <= '0;
		end
		else
		begin
			grant <= grant_next;
		end
	end

	// ************************************************************
	// priority pointer
	// ************************************************************

	// the pointer moves past the granted requester once its credit
	// runs out and otherwise stays put, also when nobody holds the grant
	always_comb
	begin
		ptr_next = ptr;
		for (int i = 0; i < NUM_REQ; i++)
		begin
			if (grant[i] && credit_empty_next[i])
			begin
				if (i == NUM_REQ - 1)
				begin
					ptr_next = '0;
				end
				else
				begin
					ptr_next = ptr_t'(i + 1);
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ptr <= '0;
		end
		else
		begin
			ptr <= ptr_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/rotate_priority_picker.sv
`timescale 1ns/1ns
`default_nettype none

module rotate_priority_picker
	import wrr_pkg::*;
(
	input wire req_vec_t req,
	input wire ptr_t ptr,
	output req_vec_t pick
);

	// requests with the pointed requester moved down to bit zero
	req_vec_t rot_req;

	// lowest set bit of rot_req, still in rotated order
	req_vec_t rot_pick;

	// set once the scan has found its winner
	logic found;

	// maps an offset from the pointer back to a requester index
	function automatic int wrap_index(input int idx);
		int wrapped;
		wrapped = idx;
		if (wrapped >= NUM_REQ)
		begin
			wrapped = wrapped - NUM_REQ;
		end
		return wrapped;
	endfunction

	// ************************************************************
	// rotate right by ptr
	// ************************************************************

	always_comb
	begin
		rot_req = '0;
		for (int j = 0; j < NUM_REQ; j++)
		begin
			rot_req[j] = req[wrap_index(j + int'(ptr))];
		end
	end

	// ************************************************************
	// take the first request at or above the pointer
	// ************************************************************

	always_comb
	begin
		rot_pick = '0;
		found = 1'b0;
		for (int j = 0; j < NUM_REQ; j++)
		begin
			if (rot_req[j] && !found)
			begin
				rot_pick[j] = 1'b1;
				found = 1'b1;
			end
		end
	end

	// ************************************************************
	// rotate the winner back left by ptr
	// ************************************************************

	// with no request at all rot_pick is zero and so is pick
	always_comb
	begin
		pick = '0;
		for (int j = 0; j < NUM_REQ; j++)
		begin
			pick[wrap_index(j + int'(ptr))] = rot_pick[j];
		end
	end

endmodule

`default_nettype wire

// File: logic/wrr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module wrr_arbiter
	import wrr_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire req_vec_t req,
	input wire wrr_cfg_t cfg,
	output req_vec_t grant
);

	// ************************************************************
	// internal connections
	// ************************************************************

	// combinational winner for the current pointer
	req_vec_t pick;

	// current highest-priority index
	ptr_t ptr;

	// set where a requester's credit will be zero after this edge
	req_vec_t credit_empty_next;

	// ************************************************************
	// blocks
	// ************************************************************

	rotate_priority_picker u_picker (
		.req  (req),
		.ptr  (ptr),
		.pick (pick)
	);

	// the bank sees the registered grant, so a credit is spent in the
	// cycle where the grant is actually held
	credit_bank u_credit_bank (
		.clk               (clk),
		.rst_n             (rst_n),
		.req               (req),
		.grant             (grant),
		.cfg               (cfg),
		.credit_empty_next (credit_empty_next)
	);

	grant_pointer_ctrl u_grant_ctrl (
		.clk               (clk),
		.rst_n             (rst_n),
		.pick              (pick),
		.credit_empty_next (credit_empty_next),
		.grant             (grant),
		.ptr               (ptr)
	);

endmodule

`default_nettype wire

// File: logic/wrr_pkg.sv
`default_nettype none

package wrr_pkg;

	// ************************************************************
	// sizes
	// ************************************************************

	// number of requesters sharing the resource
	localparam int NUM_REQ = 8;

	// pointer wide enough to index every requester
	localparam int PTR_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

	// width of one weight and of one credit counter
	localparam int WEIGHT_W = 4;

	// ************************************************************
	// types
	// ************************************************************

	// one bit per requester, used for requests, picks, grants and flags
	typedef logic [NUM_REQ-1:0] req_vec_t;

	// index of the requester that currently has the highest priority
	typedef logic [PTR_W-1:0] ptr_t;

	// a credit count or a configured weight
	typedef logic [WEIGHT_W-1:0] credit_t;

	// weight[i] is the number of turns requester i gets per round
	typedef struct packed {
		credit_t [NUM_REQ-1:0] weight;
	} wrr_cfg_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_wrr_arbiter -Mdir obj_dir \
	&& ./obj_dir/Vtb_wrr_arbiter | tee /dev/stderr | grep -qx "test passed" \
	&& echo "simulation ok" \
	|| { echo "simulation FAILED"; exit 1; }

// File: sources.f
+incdir+tb
logic/wrr_pkg.sv
logic/rotate_priority_picker.sv
logic/credit_bank.sv
logic/grant_pointer_ctrl.sv
logic/wrr_arbiter.sv
tb/tb_clock_gen.sv
tb/tb_wrr_arbiter.sv

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
(
	output logic clk
);

	// half of the 20 ns period
	localparam int HALF_PERIOD = 10;

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#HALF_PERIOD clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// File: tb/wrr_model.svh
`ifndef WRR_MODEL_SVH
`define WRR_MODEL_SVH

// ************************************************************
// reference model of the arbiter, advanced once per clock edge
// ************************************************************

req_vec_t model_grant;
ptr_t model_ptr;
credit_t [NUM_REQ-1:0] model_credit;

// state right after reset, with every credit empty
function void reset_model();
	model_grant = '0;
	model_ptr = '0;
	model_credit = '0;
endfunction

// first requester at or after start, counting upward and wrapping
function automatic req_vec_t pick_first(input req_vec_t req_now, input ptr_t start);
	req_vec_t result;
	int idx;
	result = '0;
	for (int k = 0; k < NUM_REQ; k++)
	begin
		idx = (int'(start) + k) % NUM_REQ;
		if (req_now[idx] && result == '0)
		begin
			result[idx] = 1'b1;
		end
	end
	return result;
endfunction

// one rising edge, using the inputs that were in force before it
function void step_model(input req_vec_t req_now, input wrr_cfg_t cfg_now);
	req_vec_t pick_now;
	credit_t [NUM_REQ-1:0] credit_new;
	ptr_t ptr_new;
	logic all_empty;
	pick_now = pick_first(req_now, model_ptr);
	all_empty = 1'b1;
	for (int i = 0; i < NUM_REQ; i++)
	begin
		if (model_credit[i] != '0)
		begin
			all_empty = 1'b0;
		end
	end
	// an empty counter stays at zero even when its requester is granted
	for (int i = 0; i < NUM_REQ; i++)
	begin
		if (all_empty)
		begin
			credit_new[i] = cfg_now.weight[i];
		end
		else if (model_grant[i] && req_now[i] && model_credit[i] != '0)
		begin
			credit_new[i] = model_credit[i] - credit_t'(1);
		end
		else
		begin
			credit_new[i] = model_credit[i];
		end
	end
	ptr_new = model_ptr;
	for (int i = 0; i < NUM_REQ; i++)
	begin
		if (model_grant[i] && credit_new[i] == '0)
		begin
			ptr_new = ptr_t'((i + 1) % NUM_REQ);
		end
	end
	model_grant = pick_now & ~model_grant;
	model_credit = credit_new;
	model_ptr = ptr_new;
endfunction

`endif

// File: tb/tb_wrr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module tb_wrr_arbiter
	import wrr_pkg::*;
();

	localparam int PHASE_LEN = 200;
	localparam int RUN_CYCLES = 3 * PHASE_LEN;
	localparam int RESET_TIMEOUT = 10;
	localparam int WATCHDOG_CYCLES = RUN_CYCLES + 100;

	logic clk;
	logic rst_n;
	req_vec_t req;
	wrr_cfg_t cfg;
	req_vec_t grant;

	// requests in force before the last edge and the grant seen one cycle earlier
	req_vec_t prev_req;
	req_vec_t prev_grant;
	logic run_done;

	`include "wrr_model.svh"

	tb_clock_gen u_clk_gen (
		.clk (clk)
	);

	wrr_arbiter u_dut (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req),
		.cfg   (cfg),
		.grant (grant)
	);

	// ************************************************************
	// reporting and checks
	// ************************************************************

	task automatic report_error(input string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		$display("test failed");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic report_timeout(input string msg);
		$display("timeout: %s", msg);
		$display("test failed");
		$fatal(1, "stopped on a timeout");
	endtask

	task automatic check_grant(input req_vec_t actual, input req_vec_t expected,
		input string what);
		if (actual !== expected)
		begin
			report_error($sformatf("%s: grant %b, expected %b", what, actual, expected));
		end
	endtask

	task automatic check_ptr(input ptr_t actual, input ptr_t expected);
		if (actual !== expected)
		begin
			report_error($sformatf("pointer %0d, expected %0d", actual, expected));
		end
	endtask

	// at most one bit, only a previous requester, never the same one twice in a row
	task automatic check_legal_grant(input req_vec_t actual);
		if ($countones(actual) > 1)
		begin
			report_error($sformatf("grant %b has more than one bit set", actual));
		end
		if ((actual & ~prev_req) != '0)
		begin
			report_error($sformatf("grant %b without request %b", actual, prev_req));
		end
		if ((actual & prev_grant) != '0)
		begin
			report_error($sformatf("grant %b repeats grant %b", actual, prev_grant));
		end
	endtask

	// ************************************************************
	// stimulus
	// ************************************************************

	function automatic req_vec_t lowest_bit(input req_vec_t v);
		return v & (~v + req_vec_t'(1));
	endfunction

	// about a quarter of the weights are zero
	function automatic wrr_cfg_t random_cfg();
		wrr_cfg_t c;
		for (int i = 0; i < NUM_REQ; i++)
		begin
			if ($urandom_range(3) == 0)
			begin
				c.weight[i] = '0;
			end
			else
			begin
				c.weight[i] = credit_t'($urandom_range(15));
			end
		end
		return c;
	endfunction

	// random patterns, then everyone requesting, then granted requesters letting go
	function automatic req_vec_t next_req(input int cycle, input req_vec_t granted);
		req_vec_t r;
		if (cycle < PHASE_LEN)
		begin
			r = req_vec_t'($urandom) & req_vec_t'($urandom);
		end
		else
		begin
			r = '1;
			if (cycle >= 2 * PHASE_LEN && $urandom_range(1) == 1)
			begin
				r = r & ~granted;
			end
		end
		return r;
	endfunction

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (rst_n !== 1'b1)
		begin
			if (waited == RESET_TIMEOUT)
			begin
				report_timeout("reset was never released");
			end
			@(negedge clk);
			waited++;
		end
	endtask

	// ************************************************************
	// main sequence
	// ************************************************************

	initial
	begin
		logic first_seen;
		rst_n = 1'b0;
		req = '0;
		cfg = '0;
		prev_req = '0;
		prev_grant = '0;
		run_done = 1'b0;
		first_seen = 1'b0;
		void'($urandom(32'hf79f555e));
		reset_model();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		wait_reset_release();
		check_grant(grant, '0, "after reset release");
		check_ptr(u_dut.ptr, '0);
		for (int cycle = 0; cycle < RUN_CYCLES; cycle++)
		begin
			@(posedge clk);
			prev_req = req;
			step_model(req, cfg);
			req <= next_req(cycle, model_grant);
			// weights may change at any time but only count at a reload
			if (cycle == 0 || (cycle >= PHASE_LEN && $urandom_range(15) == 0))
			begin
				cfg <= random_cfg();
			end
			@(negedge clk);
			check_legal_grant(grant);
			if (!first_seen && grant != '0)
			begin
				first_seen = 1'b1;
				check_grant(grant, lowest_bit(prev_req), "first grant after reset");
			end
			check_grant(grant, model_grant, "model compare");
			check_ptr(u_dut.ptr, model_ptr);
			prev_grant = grant;
		end
		run_done = 1'b1;
		$display("test passed");
		$finish;
	end

	initial
	begin
		int waited;
		waited = 0;
		while (!run_done && waited < WATCHDOG_CYCLES)
		begin
			@(posedge clk);
			waited++;
		end
		if (!run_done)
		begin
			report_timeout($sformatf("run did not finish within %0d cycles", WATCHDOG_CYCLES));
		end
	end

endmodule

`default_nettype wire
